// File: hdl/fdsq_config.svh
/*
 * Constants of the binary32 divide and square-root unit
 * Field widths, bias, recurrence length, latency, canonical NaN
 */
`ifndef FDSQ_CONFIG_SVH
`define FDSQ_CONFIG_SVH

// binary32 field widths
`define FDSQ_EXP_W   8
`define FDSQ_MANT_W  23
`define FDSQ_BIAS    127

// Recurrence steps, 24 result bits plus guard and round
`define FDSQ_ITER    26

// Cycles from an accepted start to done
`define FDSQ_LATENCY 29

// Canonical quiet NaN
`define FDSQ_QNAN    32'h7fc00000

`endif

// File: hdl/fdsq_pkg.sv
/*
 * Shared types of the divide and square-root unit
 * Operation, rounding mode and operand class enums
 */
package fdsq_pkg;

   // Operation in flight
   typedef enum logic {
      OP_DIV  = 1'b0,
      OP_SQRT = 1'b1
   } fdsq_op_e;

   // IEEE-754 rounding modes
   typedef enum logic [1:0] {
      RM_RNE = 2'd0,
      RM_RTZ = 2'd1,
      RM_RDN = 2'd2,
      RM_RUP = 2'd3
   } fdsq_rm_e;

   // Operand class, subnormals count as zero
   typedef enum logic [1:0] {
      CLS_NORM = 2'd0,
      CLS_ZERO = 2'd1,
      CLS_INF  = 2'd2,
      CLS_NAN  = 2'd3
   } fdsq_class_e;

endpackage

// File: hdl/fdsq_preprocess.sv
/*
 * Operand preprocessor
 * Start acceptance, operand split and classification,
 * result sign and exponent, mantissa setup for the core
 */
`include "fdsq_config.svh"

module fdsq_preprocess (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           div_start,
   input  logic                           sqrt_start,
   input  logic                           ready,
   input  logic [31:0]                    operand_a,
   input  logic [31:0]                    operand_b,
   input  fdsq_pkg::fdsq_rm_e             rnd_mode,
   output logic                           load,
   output fdsq_pkg::fdsq_op_e             op,
   output fdsq_pkg::fdsq_rm_e             rm,
   output logic                           sign_z,
   output logic signed [`FDSQ_EXP_W+1:0]  exp_z,
   output logic [`FDSQ_MANT_W:0]          mant_a,
   output logic [`FDSQ_MANT_W:0]          mant_b,
   output fdsq_pkg::fdsq_class_e          class_a,
   output fdsq_pkg::fdsq_class_e          class_b
);

   localparam logic signed [`FDSQ_EXP_W+1:0] BIAS = `FDSQ_BIAS;

   logic                          accept;
   logic                          is_div;
   logic [`FDSQ_EXP_W-1:0]        e_a;
   logic [`FDSQ_EXP_W-1:0]        e_b;
   logic [`FDSQ_MANT_W-1:0]       f_a;
   logic [`FDSQ_MANT_W-1:0]       f_b;
   logic signed [`FDSQ_EXP_W+1:0] ue_a;
   logic signed [`FDSQ_EXP_W+1:0] ue_b;
   logic signed [`FDSQ_EXP_W+1:0] exp_nxt;
   logic [`FDSQ_MANT_W:0]         ma_nxt;
   logic [`FDSQ_MANT_W:0]         mb_nxt;

   // Class from raw fields
   function automatic fdsq_pkg::fdsq_class_e classify(
      input logic [`FDSQ_EXP_W-1:0]  e,
      input logic [`FDSQ_MANT_W-1:0] f
   );
      if (e == '0) begin
         return fdsq_pkg::CLS_ZERO;
      end else if (e == '1) begin
         return (f == '0) ? fdsq_pkg::CLS_INF : fdsq_pkg::CLS_NAN;
      end
      return fdsq_pkg::CLS_NORM;
   endfunction

   // Division wins when both starts are high
   assign accept = ready & (div_start | sqrt_start);
   assign is_div = div_start;

   assign e_a = operand_a[30:`FDSQ_MANT_W];
   assign e_b = operand_b[30:`FDSQ_MANT_W];
   assign f_a = operand_a[`FDSQ_MANT_W-1:0];
   assign f_b = operand_b[`FDSQ_MANT_W-1:0];

   // Unbiased exponents
   assign ue_a = $signed({2'b00, e_a}) - BIAS;
   assign ue_b = $signed({2'b00, e_b}) - BIAS;

   always_comb begin
      if (is_div) begin
         exp_nxt = ue_a - ue_b;
         ma_nxt  = {1'b1, f_a};
         mb_nxt  = {1'b1, f_b};
      end else begin
         // Halved exponent, floor for odd values
         exp_nxt = ue_a >>> 1;
         // Radicand is {mant_a, mant_b[msb]} with two integer bits
         if (ue_a[0]) begin
            // Odd exponent, mantissa moved one place left
            ma_nxt = {1'b1, f_a};
            mb_nxt = '0;
         end else begin
            ma_nxt = {2'b01, f_a[`FDSQ_MANT_W-1:1]};
            mb_nxt = {f_a[0], {(`FDSQ_MANT_W){1'b0}}};
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Operand registers, held through the operation
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         load <= 1'b0;
      end else begin
         load <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         op      <= is_div ? fdsq_pkg::OP_DIV : fdsq_pkg::OP_SQRT;
         rm      <= rnd_mode;
         // Sign of a alone for the root
         sign_z  <= is_div ? (operand_a[31] ^ operand_b[31]) : operand_a[31];
         exp_z   <= exp_nxt;
         mant_a  <= ma_nxt;
         mant_b  <= mb_nxt;
         class_a <= classify(e_a, f_a);
         class_b <= classify(e_b, f_b);
      end
   end

endmodule

// File: hdl/fdsq_iter_core.sv
/*
 * Iterative restoring core
 * Shared subtractor for divide and square root, one bit per cycle,
 * sticky bit from the final remainder, ready generation
 */
`include "fdsq_config.svh"

module fdsq_iter_core (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           load,
   input  fdsq_pkg::fdsq_op_e             op,
   input  logic signed [`FDSQ_EXP_W+1:0]  exp_z,
   input  logic [`FDSQ_MANT_W:0]          mant_a,
   input  logic [`FDSQ_MANT_W:0]          mant_b,
   output logic                           ready,
   output logic                           finish,
   output logic [`FDSQ_MANT_W+2:0]        mant_q,
   output logic                           sticky,
   output logic signed [`FDSQ_EXP_W+1:0]  exp_q
);

   // Remainder width, covers the shifted root remainder
   localparam int REM_W = `FDSQ_MANT_W + 7;
   localparam int Q_W   = `FDSQ_MANT_W + 3;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ITER,
      ST_FINISH
   } state_e;

   state_e           state;
   logic [4:0]       cnt;
   logic [REM_W-1:0] rem;
   logic [REM_W-1:0] rem_nxt;
   logic [Q_W-1:0]   rad;
   logic [REM_W-1:0] sub_a;
   logic [REM_W-1:0] sub_b;
   logic [REM_W:0]   diff;
   logic [REM_W-1:0] keep;
   logic             q_bit;
   logic             start_run;

   assign start_run = (state == ST_IDLE) && load;

   // Low from the cycle after acceptance until done
   assign ready = (state == ST_IDLE) && !load;

   ////////////////////////////////////////////////////////////////////
   // Shared subtractor
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      if (op == fdsq_pkg::OP_DIV) begin
         // Partial remainder minus divisor
         sub_a = rem;
         sub_b = {{(REM_W-`FDSQ_MANT_W-1){1'b0}}, mant_b};
      end else begin
         // Remainder with next radicand pair minus 4*root + 1
         sub_a = {rem[REM_W-3:0], rad[Q_W-1:Q_W-2]};
         sub_b = {2'b00, mant_q, 2'b01};
      end
      diff  = {1'b0, sub_a} - {1'b0, sub_b};
      // No borrow means the trial bit is one
      q_bit = ~diff[REM_W];
      keep  = q_bit ? diff[REM_W-1:0] : sub_a;
      // Divide shifts after the step, root before it
      if (op == fdsq_pkg::OP_DIV) begin
         rem_nxt = {keep[REM_W-2:0], 1'b0};
      end else begin
         rem_nxt = keep;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Controller
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= ST_IDLE;
         cnt    <= '0;
         finish <= 1'b0;
         sticky <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (load) begin
                  state <= ST_ITER;
                  cnt   <= '0;
               end
            end
            ST_ITER: begin
               cnt <= cnt + 5'd1;
               if (cnt == 5'(`FDSQ_ITER - 1)) begin
                  state <= ST_FINISH;
               end
            end
            ST_FINISH: begin
               // Two cycles, finish pulses in the second
               if (!finish) begin
                  finish <= 1'b1;
                  sticky <= |rem;
               end else begin
                  finish <= 1'b0;
                  state  <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Datapath
   always_ff @(posedge clk) begin
      if (start_run) begin
         // Dividend as first partial remainder, root starts empty
         rem    <= (op == fdsq_pkg::OP_DIV) ?
                   {{(REM_W-`FDSQ_MANT_W-1){1'b0}}, mant_a} : '0;
         rad    <= {mant_a, mant_b[`FDSQ_MANT_W], 1'b0};
         mant_q <= '0;
         exp_q  <= exp_z;
      end else if (state == ST_ITER) begin
         rem    <= rem_nxt;
         rad    <= {rad[Q_W-3:0], 2'b00};
         mant_q <= {mant_q[Q_W-2:0], q_bit};
      end
   end

endmodule

// File: hdl/fdsq_norm_round.sv
/*
 * Normalize and round stage
 * Leading-bit fix, rounding in four modes, exponent range,
 * special operand overrides, result and flag registers
 */
`include "fdsq_config.svh"

module fdsq_norm_round (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           finish,
   input  fdsq_pkg::fdsq_op_e             op,
   input  fdsq_pkg::fdsq_rm_e             rm,
   input  logic                           sign_z,
   input  fdsq_pkg::fdsq_class_e          class_a,
   input  fdsq_pkg::fdsq_class_e          class_b,
   input  logic [`FDSQ_MANT_W+2:0]        mant_q,
   input  logic                           sticky,
   input  logic signed [`FDSQ_EXP_W+1:0]  exp_q,
   output logic                           sign_res,
   output logic [`FDSQ_EXP_W-1:0]         exp_res,
   output logic [`FDSQ_MANT_W-1:0]        mant_res,
   output logic                           exp_of,
   output logic                           exp_uf,
   output logic                           div_zero,
   output logic                           done
);

   localparam logic signed [`FDSQ_EXP_W+1:0] BIAS  = `FDSQ_BIAS;
   localparam logic signed [`FDSQ_EXP_W+1:0] E_ONE = 1;
   localparam logic [31:0]                   QNAN  = `FDSQ_QNAN;

   logic                          is_div;
   logic [`FDSQ_MANT_W:0]         m_n;
   logic                          g_bit;
   logic                          s_bit;
   logic signed [`FDSQ_EXP_W+1:0] e_n;
   logic                          rnd_up;
   logic [`FDSQ_MANT_W+1:0]       m_r;
   logic signed [`FDSQ_EXP_W+1:0] e_b;
   logic                          is_nan;
   logic                          is_dz;
   logic                          is_inf;
   logic                          is_zero;
   logic                          sign_nxt;
   logic [`FDSQ_EXP_W-1:0]        exp_nxt;
   logic [`FDSQ_MANT_W-1:0]       mant_nxt;
   logic                          of_nxt;
   logic                          uf_nxt;

   assign is_div = (op == fdsq_pkg::OP_DIV);

   ////////////////////////////////////////////////////////////////////
   // Normalize and round
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      if (mant_q[`FDSQ_MANT_W+2]) begin
         m_n   = mant_q[`FDSQ_MANT_W+2:2];
         g_bit = mant_q[1];
         s_bit = mant_q[0] | sticky;
         e_n   = exp_q;
      end else begin
         // Quotient below one, shift up
         m_n   = mant_q[`FDSQ_MANT_W+1:1];
         g_bit = mant_q[0];
         s_bit = sticky;
         e_n   = exp_q - E_ONE;
      end
      case (rm)
         fdsq_pkg::RM_RNE: rnd_up = g_bit & (s_bit | m_n[0]);
         fdsq_pkg::RM_RTZ: rnd_up = 1'b0;
         fdsq_pkg::RM_RDN: rnd_up = sign_z & (g_bit | s_bit);
         default:          rnd_up = ~sign_z & (g_bit | s_bit);
      endcase
      m_r = {1'b0, m_n} + {{(`FDSQ_MANT_W+1){1'b0}}, rnd_up};
      // Carry out of rounding bumps the exponent
      e_b = e_n + BIAS;
      if (m_r[`FDSQ_MANT_W+1]) begin
         e_b = e_b + E_ONE;
      end
   end

   // Special operand decode
   assign is_nan  = (class_a == fdsq_pkg::CLS_NAN)
                  | (is_div & (class_b == fdsq_pkg::CLS_NAN))
                  | (is_div & (class_a == fdsq_pkg::CLS_ZERO) & (class_b == fdsq_pkg::CLS_ZERO))
                  | (is_div & (class_a == fdsq_pkg::CLS_INF) & (class_b == fdsq_pkg::CLS_INF))
                  | (~is_div & sign_z & (class_a != fdsq_pkg::CLS_ZERO));
   assign is_dz   = is_div & (class_a == fdsq_pkg::CLS_NORM) & (class_b == fdsq_pkg::CLS_ZERO);
   assign is_inf  = (class_a == fdsq_pkg::CLS_INF);
   assign is_zero = (class_a == fdsq_pkg::CLS_ZERO)
                  | (is_div & (class_b == fdsq_pkg::CLS_INF));

   ////////////////////////////////////////////////////////////////////
   // Result select
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      sign_nxt = sign_z;
      of_nxt   = 1'b0;
      uf_nxt   = 1'b0;
      exp_nxt  = e_b[`FDSQ_EXP_W-1:0];
      // Rounding carry leaves an all-zero fraction
      mant_nxt = m_r[`FDSQ_MANT_W-1:0];
      if (is_nan) begin
         sign_nxt = QNAN[31];
         exp_nxt  = QNAN[30:`FDSQ_MANT_W];
         mant_nxt = QNAN[`FDSQ_MANT_W-1:0];
      end else if (is_dz || is_inf) begin
         exp_nxt  = '1;
         mant_nxt = '0;
      end else if (is_zero) begin
         exp_nxt  = '0;
         mant_nxt = '0;
      end else if (e_b >= $signed({2'b00, {(`FDSQ_EXP_W){1'b1}}})) begin
         of_nxt = 1'b1;
         // Infinity unless the mode rounds toward zero for this sign
         if ((rm == fdsq_pkg::RM_RNE) || ((rm == fdsq_pkg::RM_RUP) && !sign_z) ||
             ((rm == fdsq_pkg::RM_RDN) && sign_z)) begin
            exp_nxt  = '1;
            mant_nxt = '0;
         end else begin
            exp_nxt  = {{(`FDSQ_EXP_W-1){1'b1}}, 1'b0};
            mant_nxt = '1;
         end
      end else if (e_b <= 0) begin
         // Flush to signed zero
         uf_nxt   = 1'b1;
         exp_nxt  = '0;
         mant_nxt = '0;
      end
   end

   // Outputs held until the next finish
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sign_res <= 1'b0;
         exp_res  <= '0;
         mant_res <= '0;
         exp_of   <= 1'b0;
         exp_uf   <= 1'b0;
         div_zero <= 1'b0;
         done     <= 1'b0;
      end else begin
         done <= finish;
         if (finish) begin
            sign_res <= sign_nxt;
            exp_res  <= exp_nxt;
            mant_res <= mant_nxt;
            exp_of   <= of_nxt;
            exp_uf   <= uf_nxt;
            div_zero <= is_dz;
         end
      end
   end

endmodule

// File: hdl/fdsq_top.sv
/*
 * Top of the divide and square-root unit
 * Preprocess, iterative core and rounder, result packing
 */
`include "fdsq_config.svh"

module fdsq_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               div_start,
   input  logic               sqrt_start,
   input  logic [31:0]        operand_a,
   input  logic [31:0]        operand_b,
   input  fdsq_pkg::fdsq_rm_e rnd_mode,
   output logic [31:0]        result,
   output logic               exp_of,
   output logic               exp_uf,
   output logic               div_zero,
   output logic               ready,
   output logic               done
);

   // Preprocess outputs
   logic                          load;
   fdsq_pkg::fdsq_op_e            op;
   fdsq_pkg::fdsq_rm_e            rm;
   logic                          sign_z;
   logic signed [`FDSQ_EXP_W+1:0] exp_z;
   logic [`FDSQ_MANT_W:0]         mant_a;
   logic [`FDSQ_MANT_W:0]         mant_b;
   fdsq_pkg::fdsq_class_e         class_a;
   fdsq_pkg::fdsq_class_e         class_b;

   // Core outputs
   logic                          finish;
   logic [`FDSQ_MANT_W+2:0]       mant_q;
   logic                          sticky;
   logic signed [`FDSQ_EXP_W+1:0] exp_q;

   // Result fields
   logic                          sign_res;
   logic [`FDSQ_EXP_W-1:0]        exp_res;
   logic [`FDSQ_MANT_W-1:0]       mant_res;

   assign result = {sign_res, exp_res, mant_res};

   fdsq_preprocess i_preprocess (
      .clk        (clk),
      .rst_n      (rst_n),
      .div_start  (div_start),
      .sqrt_start (sqrt_start),
      .ready      (ready),
      .operand_a  (operand_a),
      .operand_b  (operand_b),
      .rnd_mode   (rnd_mode),
      .load       (load),
      .op         (op),
      .rm         (rm),
      .sign_z     (sign_z),
      .exp_z      (exp_z),
      .mant_a     (mant_a),
      .mant_b     (mant_b),
      .class_a    (class_a),
      .class_b    (class_b)
   );

   fdsq_iter_core i_iter_core (
      .clk    (clk),
      .rst_n  (rst_n),
      .load   (load),
      .op     (op),
      .exp_z  (exp_z),
      .mant_a (mant_a),
      .mant_b (mant_b),
      .ready  (ready),
      .finish (finish),
      .mant_q (mant_q),
      .sticky (sticky),
      .exp_q  (exp_q)
   );

   fdsq_norm_round i_norm_round (
      .clk      (clk),
      .rst_n    (rst_n),
      .finish   (finish),
      .op       (op),
      .rm       (rm),
      .sign_z   (sign_z),
      .class_a  (class_a),
      .class_b  (class_b),
      .mant_q   (mant_q),
      .sticky   (sticky),
      .exp_q    (exp_q),
      .sign_res (sign_res),
      .exp_res  (exp_res),
      .mant_res (mant_res),
      .exp_of   (exp_of),
      .exp_uf   (exp_uf),
      .div_zero (div_zero),
      .done     (done)
   );

endmodule

// File: bench/fdsq_tb.sv
/*
 * Testbench of the divide and square-root unit
 * Vector file reader, start driver with busy-time start injection,
 * latency, handshake, result and flag compare tasks, watchdog
 */
`include "fdsq_config.svh"

module fdsq_tb;

   localparam int CLK_HALF = 4;
   localparam int LAT      = `FDSQ_LATENCY;

   logic               clk;
   logic               rst_n;
   logic               div_start;
   logic               sqrt_start;
   logic [31:0]        operand_a;
   logic [31:0]        operand_b;
   fdsq_pkg::fdsq_rm_e rnd_mode;
   logic [31:0]        result;
   logic               exp_of;
   logic               exp_uf;
   logic               div_zero;
   logic               ready;
   logic               done;

   // Vectors as read from the data file
   int          vec_op[$];
   int          vec_rm[$];
   logic [31:0] vec_a[$];
   logic [31:0] vec_b[$];
   logic [31:0] vec_res[$];
   logic [2:0]  vec_flags[$];

   int          num_vec;
   bit          vectors_loaded;
   int          test_errors;
   int          pass_count;
   int          fail_count;
   int          idx;

   fdsq_top i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .div_start  (div_start),
      .sqrt_start (sqrt_start),
      .operand_a  (operand_a),
      .operand_b  (operand_b),
      .rnd_mode   (rnd_mode),
      .result     (result),
      .exp_of     (exp_of),
      .exp_uf     (exp_uf),
      .div_zero   (div_zero),
      .ready      (ready),
      .done       (done)
   );

   initial clk = 1'b0;
   always #(CLK_HALF) clk = ~clk;

   ////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////

   task automatic check_result(input fdsq_pkg::fdsq_op_e op, input logic [31:0] expected);
      if (result !== expected) begin
         $display("Mismatch at %0t: %s result 0x%08h, expected 0x%08h",
                  $time, op.name(), result, expected);
         test_errors++;
      end
   endtask

   task automatic check_flags(input logic of_exp, input logic uf_exp, input logic dz_exp);
      if ({exp_of, exp_uf, div_zero} !== {of_exp, uf_exp, dz_exp}) begin
         $display("Mismatch at %0t: flags of/uf/dz %b%b%b, expected %b%b%b",
                  $time, exp_of, exp_uf, div_zero, of_exp, uf_exp, dz_exp);
         test_errors++;
      end
   endtask

   task automatic check_handshake(input logic ready_exp, input logic done_exp);
      if ({ready, done} !== {ready_exp, done_exp}) begin
         $display("Mismatch at %0t: ready/done %b%b, expected %b%b",
                  $time, ready, done, ready_exp, done_exp);
         test_errors++;
      end
   endtask

   task automatic check_latency(input int cycles);
      if (cycles != LAT) begin
         $display("Mismatch at %0t: done after %0d cycles, expected %0d",
                  $time, cycles, LAT);
         test_errors++;
      end
   endtask

   // Skips comment and empty lines
   task automatic load_vectors();
      int          fd;
      int          cnt;
      int          op;
      int          rm;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [2:0]  flags;
      string       line;
      fd = $fopen("bench/fdsq_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file bench/fdsq_testdata.txt");
         fail_count++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
               cnt = $sscanf(line, "%d %d %h %h %h %b", op, rm, a, b, res, flags);
               if (cnt == 6) begin
                  vec_op.push_back(op);
                  vec_rm.push_back(rm);
                  vec_a.push_back(a);
                  vec_b.push_back(b);
                  vec_res.push_back(res);
                  vec_flags.push_back(flags);
               end else begin
                  $display("Malformed vector line skipped: %s", line);
                  fail_count++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic check_reset_state();
      test_errors = 0;
      @(negedge clk);
      check_handshake(1'b1, 1'b0);
      check_result(fdsq_pkg::OP_DIV, 32'h0);
      check_flags(1'b0, 1'b0, 1'b0);
      $display("test reset state: %s", (test_errors == 0) ? "ok" : "error");
      if (test_errors == 0) begin
         pass_count++;
      end else begin
         fail_count++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // One vector, with a start pulse injected while busy
   ////////////////////////////////////////////////////////////////////

   task automatic run_vector(input int n);
      fdsq_pkg::fdsq_op_e op;
      int                 cycles;
      int                 inject_at;
      bit                 got_done;
      bit                 pick;
      op        = (vec_op[n] == 1) ? fdsq_pkg::OP_SQRT : fdsq_pkg::OP_DIV;
      inject_at = $urandom_range(20, 1);
      pick      = 1'($urandom_range(1, 0));
      test_errors = 0;
      @(negedge clk);
      check_handshake(1'b1, 1'b0);
      @(posedge clk);
      // Op code 2 raises both starts
      div_start  <= (vec_op[n] != 1);
      sqrt_start <= (vec_op[n] != 0);
      operand_a  <= vec_a[n];
      operand_b  <= vec_b[n];
      rnd_mode   <= fdsq_pkg::fdsq_rm_e'(vec_rm[n]);
      // Accepting edge
      @(posedge clk);
      div_start  <= 1'b0;
      sqrt_start <= 1'b0;
      cycles   = 0;
      got_done = 1'b0;
      while (!got_done && cycles <= LAT + 4) begin
         @(negedge clk);
         if (done) begin
            got_done = 1'b1;
         end else begin
            // Busy, ready must stay low
            check_handshake(1'b0, 1'b0);
            @(posedge clk);
            cycles++;
            if (cycles == inject_at) begin
               div_start  <= ~pick;
               sqrt_start <= pick;
               operand_a  <= $urandom();
               operand_b  <= $urandom();
               rnd_mode   <= fdsq_pkg::fdsq_rm_e'($urandom_range(3, 0));
            end else if (cycles == inject_at + 1) begin
               div_start  <= 1'b0;
               sqrt_start <= 1'b0;
            end
         end
      end
      if (!got_done) begin
         $display("No done within %0d cycles after the start of test %0d", cycles, n);
         test_errors++;
      end else begin
         check_latency(cycles);
         check_result(op, vec_res[n]);
         check_flags(vec_flags[n][2], vec_flags[n][1], vec_flags[n][0]);
         // Ready returns together with done
         check_handshake(1'b1, 1'b1);
      end
      $display("test %0d %s rm %0d a 0x%08h b 0x%08h result 0x%08h: %s", n, op.name(),
               vec_rm[n], vec_a[n], vec_b[n], result, (test_errors == 0) ? "ok" : "error");
      if (test_errors == 0) begin
         pass_count++;
      end else begin
         fail_count++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(32'h96f8));
      rst_n          = 1'b0;
      div_start      = 1'b0;
      sqrt_start     = 1'b0;
      operand_a      = '0;
      operand_b      = '0;
      rnd_mode       = fdsq_pkg::RM_RNE;
      pass_count     = 0;
      fail_count     = 0;
      vectors_loaded = 1'b0;
      load_vectors();
      num_vec        = vec_op.size();
      vectors_loaded = 1'b1;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      check_reset_state();
      for (idx = 0; idx < num_vec; idx++) begin
         // Idle gap of 0 to 5 cycles
         repeat ($urandom_range(5, 0)) @(posedge clk);
         run_vector(idx);
      end
      $display("Tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0 && num_vec > 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Watchdog, sized from the vector count
   initial begin
      wait (vectors_loaded);
      repeat (num_vec * (LAT + 8) + 100) @(posedge clk);
      $display("Watchdog expired after %0d cycles, run did not complete",
               num_vec * (LAT + 8) + 100);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: all.f
+incdir+hdl
hdl/fdsq_pkg.sv
hdl/fdsq_preprocess.sv
hdl/fdsq_iter_core.sv
hdl/fdsq_norm_round.sv
hdl/fdsq_top.sv
bench/fdsq_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the divide and square-root testbench with Verilator and runs it.
# The verdict comes from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=fdsq_sim

verilator --binary -Wno-fatal --top-module fdsq_tb -f all.f -o "$EXE"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"$EXE" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation executable returned status $run_status"
   exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
   exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
   echo "No verdict found in $LOG"
   exit 1
fi
exit 0

// File: bench/fdsq_testdata.txt
# op: 0 div, 1 sqrt, 2 both starts (division expected)   rm: 0 rne, 1 rtz, 2 rdn, 3 rup
# op rm operand_a operand_b expected flags(exp_of exp_uf div_zero)
0 0 40c00000 40400000 40000000 000
0 1 40c00000 40400000 40000000 000
0 2 40c00000 40400000 40000000 000
0 3 40c00000 40400000 40000000 000
1 0 40100000 00000000 3fc00000 000
1 1 40100000 00000000 3fc00000 000
1 2 40100000 00000000 3fc00000 000
1 3 40100000 00000000 3fc00000 000
0 0 3f800000 40800000 3e800000 000
1 0 41800000 00000000 40800000 000
0 0 3f800000 40400000 3eaaaaab 000
0 1 3f800000 40400000 3eaaaaaa 000
0 2 3f800000 40400000 3eaaaaaa 000
0 3 3f800000 40400000 3eaaaaab 000
0 0 40000000 40400000 3f2aaaab 000
0 2 bf800000 40400000 beaaaaab 000
0 3 bf800000 40400000 beaaaaaa 000
1 0 40000000 00000000 3fb504f3 000
1 1 40000000 00000000 3fb504f3 000
1 2 40000000 00000000 3fb504f3 000
1 3 40000000 00000000 3fb504f4 000
0 0 7fc00000 3f800000 7fc00000 000
1 0 ff800001 00000000 7fc00000 000
0 0 00000000 00000000 7fc00000 000
0 0 7f800000 7f800000 7fc00000 000
1 0 bf800000 00000000 7fc00000 000
0 0 3f800000 00000000 7f800000 001
0 0 bf800000 00000000 ff800000 001
0 0 3f800000 00000001 7f800000 001
0 0 00000000 40400000 00000000 000
0 0 80000000 40400000 80000000 000
0 0 3f800000 7f800000 00000000 000
1 0 80000000 00000000 80000000 000
1 0 7f800000 00000000 7f800000 000
0 0 7f7fffff 00800000 7f800000 100
0 1 7f7fffff 00800000 7f7fffff 100
0 3 7f7fffff 00800000 7f800000 100
0 2 ff7fffff 00800000 ff800000 100
0 3 ff7fffff 00800000 ff7fffff 100
0 0 00800000 7f7fffff 00000000 010
0 0 00800000 ff7fffff 80000000 010
2 0 40c00000 40400000 40000000 000
